// ==== project.f ====
logic/rw_engine_pkg.sv
logic/packet_if.sv
logic/packet_fifo.sv
logic/memory_response_decoder.sv
logic/request_generator.sv
logic/engine_read_write.sv
test/tb_engine_read_write.sv

// ==== Makefile ====
TOP = tb_engine_read_write

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/tb_engine_read_write.sv ====
// Testbench for the read/write engine with memory model, reference addresses and comparator
`timescale 1ns/1ps

module tb_engine_read_write;
    import rw_engine_pkg::*;

    localparam logic [31:0] SEED = 32'hceae1f8f;
    localparam int SEND_LIMIT    = 3000;
    localparam int HOLD_LIMIT    = 400;
    localparam int HOLD_EXTRA    = 30;
    localparam int SERVE_LIMIT   = 4000;
    localparam int OBSERVE_LIMIT = 2000;
    localparam int DONE_LIMIT    = 100;

    logic              ap_clk;
    logic              areset;
    logic              descriptor_valid;
    logic              response_engine_valid;
    logic [WORD_W-1:0] response_engine_word;
    logic              response_memory_valid;
    logic              response_memory_kind;
    logic [WORD_W-1:0] response_memory_word;
    logic              response_engine_full;
    logic              response_memory_full;
    logic              request_memory_ready;
    logic              request_engine_ready;
    logic              request_memory_valid;
    logic              request_memory_kind;
    logic [ADDR_W-1:0] request_memory_addr;
    logic [WORD_W-1:0] request_memory_word;
    logic              request_engine_valid;
    logic [WORD_W-1:0] request_engine_word;
    logic              done_out;

    integer               stim_seed;
    integer               ready_seed;
    integer               mem_seed;
    logic [MEM_REQ_W-1:0] exp_mreq [$];
    logic [WORD_W-1:0]    exp_ereq [$];
    logic [ADDR_W-1:0]    read_addrs [$];
    int                   error_count;
    int                   timeout_count;
    int                   reads_seen;
    int                   returns_sent;
    int                   mreq_seen;
    int                   ereq_seen;
    int                   cur_count;
    logic                 cur_write;
    logic [WORD_W-1:0]    cur_cfg;
    logic                 in_reset;
    logic                 done_seen;
    logic                 eng_full_seen;
    event                 run_over;

    engine_read_write uut (
        .ap_clk, .areset, .descriptor_valid,
        .response_engine_valid, .response_engine_word,
        .response_memory_valid, .response_memory_kind, .response_memory_word,
        .response_engine_full, .response_memory_full,
        .request_memory_ready, .request_engine_ready,
        .request_memory_valid, .request_memory_kind, .request_memory_addr,
        .request_memory_word, .request_engine_valid, .request_engine_word, .done_out
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // Expected request address is base plus index or seq times stride, modulo 2^ADDR_W
    function automatic logic [ADDR_W-1:0] expected_addr(input logic [WORD_W-1:0] cfg_word,
                                                        input logic [WORD_W-1:0] eng_word,
                                                        input int seq);
        int index;
        int stride;
        int base;
        index  = cfg_word[31] ? seq : int'(eng_word[15:0]);
        stride = int'(cfg_word[23:16]);
        base   = int'(cfg_word[15:0]);
        return ADDR_W'((base + index * stride) % 65536);
    endfunction

    // Memory contents seen by the model
    function automatic logic [WORD_W-1:0] memory_data(input logic [ADDR_W-1:0] addr);
        return {addr ^ 16'hc35a, addr + 16'h1357};
    endfunction

    // All expected requests and read returns seen at the outputs
    function automatic logic outputs_complete();
        return mreq_seen >= cur_count && (cur_write || ereq_seen >= cur_count);
    endfunction

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout at %0t while waiting for %s", $time, what);
        -> run_over;
    endtask

    // ------------------------------------------------------------------------
    // Comparator
    // ------------------------------------------------------------------------
    task automatic check_memory_request();
        logic [MEM_REQ_W-1:0] entry;
        logic                 exp_kind;
        logic [ADDR_W-1:0]    exp_addr;
        logic [WORD_W-1:0]    exp_word;
        if (request_memory_valid) begin
            if (exp_mreq.size() == 0) begin
                error_count++;
                $display("Unexpected memory request at %0t with none pending", $time);
            end else begin
                entry = exp_mreq.pop_front();
                {exp_kind, exp_addr, exp_word} = entry;
                if (request_memory_kind != exp_kind) begin
                    error_count++;
                    $display("CHECK FAILED at %0t: memory request %0d kind %0b, expected %0b",
                             $time, mreq_seen, request_memory_kind, exp_kind);
                end
                if (request_memory_addr != exp_addr) begin
                    error_count++;
                    $display("CHECK FAILED at %0t: memory request %0d addr %h, expected %h",
                             $time, mreq_seen, request_memory_addr, exp_addr);
                end
                if (exp_kind == REQ_WRITE && request_memory_word != exp_word) begin
                    error_count++;
                    $display("CHECK FAILED at %0t: memory write %0d word %h, expected %h",
                             $time, mreq_seen, request_memory_word, exp_word);
                end
                if (request_memory_kind == REQ_READ) begin
                    read_addrs.push_back(request_memory_addr);
                    reads_seen++;
                    if (reads_seen - returns_sent > MAX_OUTSTANDING) begin
                        error_count++;
                        $display("CHECK FAILED at %0t: %0d reads outstanding, limit %0d",
                                 $time, reads_seen - returns_sent, MAX_OUTSTANDING);
                    end
                end
                mreq_seen++;
            end
        end
    endtask

    task automatic check_engine_request();
        logic [WORD_W-1:0] exp_word;
        if (request_engine_valid) begin
            if (exp_ereq.size() == 0) begin
                error_count++;
                $display("Unexpected engine request at %0t with none pending", $time);
            end else begin
                exp_word = exp_ereq.pop_front();
                if (request_engine_word != exp_word) begin
                    error_count++;
                    $display("CHECK FAILED at %0t: engine request %0d word %h, expected %h",
                             $time, ereq_seen, request_engine_word, exp_word);
                end
                ereq_seen++;
            end
        end
    endtask

    // The memory response FIFO holds at most the responses not yet seen at the outputs
    task automatic check_memory_full();
        int pending;
        pending = returns_sent + 1 - ereq_seen;
        if (response_memory_full && pending < PROG_THRESH) begin
            error_count++;
            $display("CHECK FAILED at %0t: response_memory_full high with %0d responses pending",
                     $time, pending);
        end
    endtask

    task automatic check_done();
        if (done_out) begin
            if (!done_seen && !outputs_complete()) begin
                error_count++;
                $display("CHECK FAILED at %0t: done_out high after %0d/%0d requests, %0d returns",
                         $time, mreq_seen, cur_count, ereq_seen);
            end
            done_seen = 1'b1;
        end else if (done_seen) begin
            error_count++;
            $display("CHECK FAILED at %0t: done_out fell before reset", $time);
        end
    endtask

    // Outputs change on the rising edge and are compared on the falling edge
    always @(negedge ap_clk) begin
        if (!in_reset) begin
            check_memory_full();
            check_memory_request();
            check_engine_request();
            check_done();
        end
    end

    // Rare ready flips give long stretches of back-pressure
    initial begin
        request_memory_ready = 1'b1;
        request_engine_ready = 1'b1;
        forever begin
            @(posedge ap_clk);
            #1;
            if (($random(ready_seed) & 31) == 0) begin
                request_memory_ready = ~request_memory_ready;
            end
            if (($random(ready_seed) & 31) == 0) begin
                request_engine_ready = ~request_engine_ready;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus and memory model
    // ------------------------------------------------------------------------
    task automatic apply_reset();
        in_reset = 1'b1;
        @(posedge ap_clk);
        #1;
        areset                = 1'b1;
        descriptor_valid      = 1'b0;
        response_engine_valid = 1'b0;
        response_memory_valid = 1'b0;
        exp_mreq.delete();
        exp_ereq.delete();
        read_addrs.delete();
        reads_seen   = 0;
        returns_sent = 0;
        mreq_seen    = 0;
        ereq_seen    = 0;
        done_seen    = 1'b0;
        repeat (8) @(posedge ap_clk);
        #1;
        areset = 1'b0;
        // Internal reset is one register behind the port
        repeat (2) @(posedge ap_clk);
        #1;
        in_reset = 1'b0;
    endtask

    task automatic send_config();
        @(posedge ap_clk);
        #1;
        response_memory_valid = 1'b1;
        response_memory_kind  = KIND_CONFIG;
        response_memory_word  = cur_cfg;
        @(posedge ap_clk);
        #1;
        response_memory_valid = 1'b0;
        descriptor_valid      = 1'b1;
        @(posedge ap_clk);
        #1;
        descriptor_valid = 1'b0;
    endtask

    task automatic send_engine_words();
        int                sent;
        int                cycles;
        logic [WORD_W-1:0] word;
        sent   = 0;
        cycles = 0;
        while (sent < cur_count && cycles < SEND_LIMIT) begin
            @(posedge ap_clk);
            #1;
            cycles++;
            response_engine_valid = 1'b0;
            if (response_engine_full) begin
                eng_full_seen = 1'b1;
            end else begin
                word = $random(stim_seed);
                response_engine_valid = 1'b1;
                response_engine_word  = word;
                exp_mreq.push_back({cur_write ? REQ_WRITE : REQ_READ,
                                    expected_addr(cur_cfg, word, sent), word});
                sent++;
            end
        end
        @(posedge ap_clk);
        #1;
        response_engine_valid = 1'b0;
        if (sent < cur_count) begin
            report_timeout("the engine response FIFO to take words");
        end
    endtask

    task automatic serve_reads();
        int                cycles;
        int                delay;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
        cycles = 0;
        // Hold all returns until the credit limit stalls the reads
        while (reads_seen < MAX_OUTSTANDING && cycles < HOLD_LIMIT) begin
            @(posedge ap_clk);
            cycles++;
        end
        if (reads_seen < MAX_OUTSTANDING) begin
            report_timeout("reads to reach the credit limit");
            return;
        end
        repeat (HOLD_EXTRA) @(posedge ap_clk);
        cycles = 0;
        delay  = 0;
        while (returns_sent < cur_count && cycles < SERVE_LIMIT) begin
            @(posedge ap_clk);
            #1;
            cycles++;
            response_memory_valid = 1'b0;
            if (delay > 0) begin
                delay--;
            end else if (read_addrs.size() > 0 && !response_memory_full) begin
                addr = read_addrs.pop_front();
                data = memory_data(addr);
                response_memory_valid = 1'b1;
                response_memory_kind  = KIND_DATA;
                response_memory_word  = data;
                exp_ereq.push_back(data);
                returns_sent++;
                delay = $unsigned($random(mem_seed)) % 4;
                if (($random(mem_seed) & 15) == 0) begin
                    delay = delay + 25;
                end
            end
        end
        @(posedge ap_clk);
        #1;
        response_memory_valid = 1'b0;
        if (returns_sent < cur_count) begin
            report_timeout("read requests to answer");
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!outputs_complete() && cycles < OBSERVE_LIMIT) begin
            @(posedge ap_clk);
            cycles++;
        end
        if (!outputs_complete()) begin
            report_timeout("all requests at the outputs");
        end
        cycles = 0;
        while (!done_seen && cycles < DONE_LIMIT) begin
            @(posedge ap_clk);
            cycles++;
        end
        if (!done_seen) begin
            report_timeout("done_out");
        end else begin
            // Comparator flags any drop of done_out in this window
            repeat (20) @(posedge ap_clk);
        end
    endtask

    task automatic run_phase(input logic write_mode, input int count,
                             input logic [7:0] stride, input logic [15:0] base);
        apply_reset();
        cur_write = write_mode;
        cur_count = count;
        cur_cfg   = {write_mode, 7'(count), stride, base};
        send_config();
        fork
            send_engine_words();
            if (!write_mode) serve_reads();
        join
        wait_done();
    endtask

    initial begin
        stim_seed             = SEED;
        ready_seed            = SEED ^ 32'h1;
        mem_seed              = SEED ^ 32'h2;
        areset                = 1'b1;
        descriptor_valid      = 1'b0;
        response_engine_valid = 1'b0;
        response_engine_word  = '0;
        response_memory_valid = 1'b0;
        response_memory_kind  = KIND_DATA;
        response_memory_word  = '0;
        error_count           = 0;
        timeout_count         = 0;
        in_reset              = 1'b1;
        eng_full_seen         = 1'b0;
        cur_count             = 0;
        cur_write             = 1'b0;
        run_phase(1'b0, 40, 8'd12, 16'hf3a0);
        if (!eng_full_seen) begin
            error_count++;
            $display("response_engine_full never rose while the engine FIFO was backed up");
        end
        run_phase(1'b1, 30, 8'd36, 16'h0400);
        -> run_over;
    end

    initial begin
        @(run_over);
        $display("Errors: %0d failed, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/engine_read_write.sv ====
// Read/write engine top with I/O registers, four FIFOs, read credit and done
`timescale 1ns/1ps

module engine_read_write (
    input  logic                             ap_clk,
    input  logic                             areset,
    input  logic                             descriptor_valid,
    input  logic                             response_engine_valid,
    input  logic [rw_engine_pkg::WORD_W-1:0] response_engine_word,
    input  logic                             response_memory_valid,
    input  logic                             response_memory_kind,
    input  logic [rw_engine_pkg::WORD_W-1:0] response_memory_word,
    output logic                             response_engine_full,
    output logic                             response_memory_full,
    input  logic                             request_memory_ready,
    input  logic                             request_engine_ready,
    output logic                             request_memory_valid,
    output logic                             request_memory_kind,
    output logic [rw_engine_pkg::ADDR_W-1:0] request_memory_addr,
    output logic [rw_engine_pkg::WORD_W-1:0] request_memory_word,
    output logic                             request_engine_valid,
    output logic [rw_engine_pkg::WORD_W-1:0] request_engine_word,
    output logic                             done_out
);
    import rw_engine_pkg::*;

    logic areset_read_write_engine;

    // Registered inputs
    logic              descriptor_valid_reg;
    logic              eng_in_valid;
    logic [WORD_W-1:0] eng_in_word;
    logic              mem_in_valid;
    logic              mem_in_kind;
    logic [WORD_W-1:0] mem_in_word;
    logic              mem_ready_reg;
    logic              eng_ready_reg;

    // FIFO sides
    logic                 ersp_rd_en;
    logic                 ersp_valid;
    logic                 ersp_empty;
    logic                 ersp_prog_full;
    logic [WORD_W-1:0]    ersp_dout;
    logic                 mrsp_rd_en;
    logic                 mrsp_valid;
    logic                 mrsp_empty;
    logic                 mrsp_prog_full;
    logic [PACKET_W-1:0]  mrsp_dout;
    logic                 mreq_rd_en;
    logic                 mreq_valid;
    logic                 mreq_empty;
    logic                 mreq_prog_full;
    logic [MEM_REQ_W-1:0] mreq_dout;
    logic                 ereq_rd_en;
    logic                 ereq_valid;
    logic                 ereq_empty;
    logic                 ereq_prog_full;
    logic [WORD_W-1:0]    ereq_dout;

    // Decoder and generator
    mem_word_t         dec_cfg;
    logic              dec_cfg_valid;
    logic              mreq_push;
    logic              mreq_kind;
    logic [ADDR_W-1:0] mreq_addr;
    logic [WORD_W-1:0] mreq_word;
    logic              ereq_push;
    logic [WORD_W-1:0] ereq_word;
    logic              gen_done;

    logic [CREDIT_W-1:0] credit;
    logic                credit_spend;
    logic                credit_refund;
    logic                all_empty;

    packet_if mem_data_if ();

    // ---------------------------------------------------------------------------
    // Input registers
    // ---------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_read_write_engine <= areset;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            descriptor_valid_reg <= 1'b0;
            eng_in_valid         <= 1'b0;
            mem_in_valid         <= 1'b0;
            mem_ready_reg        <= 1'b0;
            eng_ready_reg        <= 1'b0;
        end else begin
            descriptor_valid_reg <= descriptor_valid;
            eng_in_valid         <= response_engine_valid;
            mem_in_valid         <= response_memory_valid;
            mem_ready_reg        <= request_memory_ready;
            eng_ready_reg        <= request_engine_ready;
        end
    end

    always_ff @(posedge ap_clk) begin
        eng_in_word <= response_engine_word;
        mem_in_kind <= response_memory_kind;
        mem_in_word <= response_memory_word;
    end

    // ---------------------------------------------------------------------------
    // FIFOs
    // ---------------------------------------------------------------------------
    packet_fifo #(.WIDTH(WORD_W)) u_fifo_response_engine (
        .ap_clk, .areset_read_write_engine,
        .din(eng_in_word), .wr_en(eng_in_valid), .rd_en(ersp_rd_en),
        .dout(ersp_dout), .valid(ersp_valid), .empty(ersp_empty),
        .full(), .prog_full(ersp_prog_full)
    );

    packet_fifo #(.WIDTH(PACKET_W)) u_fifo_response_memory (
        .ap_clk, .areset_read_write_engine,
        .din({mem_in_kind, mem_in_word}), .wr_en(mem_in_valid), .rd_en(mrsp_rd_en),
        .dout(mrsp_dout), .valid(mrsp_valid), .empty(mrsp_empty),
        .full(), .prog_full(mrsp_prog_full)
    );

    // Reads wait for a credit, writes only for ready
    assign mreq_rd_en = !mreq_empty && mem_ready_reg
                        && (dec_cfg.cfg.write_mode || credit != '0);

    packet_fifo #(.WIDTH(MEM_REQ_W)) u_fifo_request_memory (
        .ap_clk, .areset_read_write_engine,
        .din({mreq_kind, mreq_addr, mreq_word}), .wr_en(mreq_push), .rd_en(mreq_rd_en),
        .dout(mreq_dout), .valid(mreq_valid), .empty(mreq_empty),
        .full(), .prog_full(mreq_prog_full)
    );

    assign ereq_rd_en = !ereq_empty && eng_ready_reg;

    packet_fifo #(.WIDTH(WORD_W)) u_fifo_request_engine (
        .ap_clk, .areset_read_write_engine,
        .din(ereq_word), .wr_en(ereq_push), .rd_en(ereq_rd_en),
        .dout(ereq_dout), .valid(ereq_valid), .empty(ereq_empty),
        .full(), .prog_full(ereq_prog_full)
    );

    // ---------------------------------------------------------------------------
    // Decoder and generator
    // ---------------------------------------------------------------------------
    memory_response_decoder u_decoder (
        .ap_clk, .areset_read_write_engine,
        .fifo_valid(mrsp_valid), .fifo_kind(mrsp_dout[WORD_W]),
        .fifo_word(mrsp_dout[WORD_W-1:0]), .fifo_empty(mrsp_empty),
        .fifo_rd_en(mrsp_rd_en), .cfg_valid(dec_cfg_valid), .cfg(dec_cfg),
        .data(mem_data_if.source)
    );

    request_generator u_generator (
        .ap_clk, .areset_read_write_engine,
        .start(descriptor_valid_reg), .cfg_valid(dec_cfg_valid), .cfg(dec_cfg),
        .eng_valid(ersp_valid), .eng_word(ersp_dout), .eng_empty(ersp_empty),
        .eng_rd_en(ersp_rd_en), .mem_data(mem_data_if.sink),
        .mreq_push, .mreq_kind, .mreq_addr, .mreq_word, .mreq_prog_full,
        .ereq_push, .ereq_word, .ereq_prog_full, .gen_done
    );

    // ---------------------------------------------------------------------------
    // Read credit bounding outstanding reads
    // ---------------------------------------------------------------------------
    assign credit_spend  = mreq_rd_en && !dec_cfg.cfg.write_mode;
    assign credit_refund = ereq_push;

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            credit <= CREDIT_W'(MAX_OUTSTANDING);
        end else if (credit_spend && !credit_refund) begin
            credit <= credit - 1'b1;
        end else if (credit_refund && !credit_spend) begin
            credit <= credit + 1'b1;
        end
    end

    // A return without a matching issued read would push past the limit
    a_credit_bounds: assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
        (credit <= CREDIT_W'(MAX_OUTSTANDING))
        && !(credit_refund && !credit_spend && credit == CREDIT_W'(MAX_OUTSTANDING)));

    // ---------------------------------------------------------------------------
    // Output registers and done
    // ---------------------------------------------------------------------------
    assign all_empty = ersp_empty && mrsp_empty && mreq_empty && ereq_empty;

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            request_memory_valid <= 1'b0;
            request_engine_valid <= 1'b0;
            response_engine_full <= 1'b0;
            response_memory_full <= 1'b0;
            done_out             <= 1'b0;
        end else begin
            request_memory_valid <= mreq_valid;
            request_engine_valid <= ereq_valid;
            response_engine_full <= ersp_prog_full;
            response_memory_full <= mrsp_prog_full;
            // Sticky until the next reset
            done_out             <= done_out || (gen_done && all_empty);
        end
    end

    always_ff @(posedge ap_clk) begin
        {request_memory_kind, request_memory_addr, request_memory_word} <= mreq_dout;
        request_engine_word <= ereq_dout;
    end

endmodule

// ==== logic/request_generator.sv ====
// Request generator issuing memory requests and forwarding read data
`timescale 1ns/1ps

module request_generator (
    input  logic                                ap_clk,
    input  logic                                areset_read_write_engine,
    input  logic                                start,
    input  logic                                cfg_valid,
    input  rw_engine_pkg::mem_word_t            cfg,
    input  logic                                eng_valid,
    input  rw_engine_pkg::mem_word_t            eng_word,
    input  logic                                eng_empty,
    output logic                                eng_rd_en,
    packet_if.sink                              mem_data,
    output logic                                mreq_push,
    output logic                                mreq_kind,
    output logic [rw_engine_pkg::ADDR_W-1:0]    mreq_addr,
    output logic [rw_engine_pkg::WORD_W-1:0]    mreq_word,
    input  logic                                mreq_prog_full,
    output logic                                ereq_push,
    output logic [rw_engine_pkg::WORD_W-1:0]    ereq_word,
    input  logic                                ereq_prog_full,
    output logic                                gen_done
);
    import rw_engine_pkg::*;

    logic               started;
    logic [COUNT_W-1:0] popped;
    logic [COUNT_W-1:0] issued;
    logic [COUNT_W-1:0] returned;
    logic [ADDR_W-1:0]  index;
    logic [ADDR_W-1:0]  offset;
    logic               all_issued;
    logic               all_returned;

    // ---------------------------------------------------------------------------
    // Request issue
    // ---------------------------------------------------------------------------
    // Stop popping once count responses are in flight or issued
    assign eng_rd_en = started && cfg_valid && !eng_empty && !mreq_prog_full
                       && (popped < cfg.cfg.count);

    // Write mode walks a sequence, read mode uses the engine index
    assign index  = cfg.cfg.write_mode ? ADDR_W'(issued) : eng_word.data[ADDR_W-1:0];
    assign offset = index * cfg.cfg.stride;

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            started   <= 1'b0;
            popped    <= '0;
            issued    <= '0;
            mreq_push <= 1'b0;
        end else begin
            mreq_push <= eng_valid;
            if (start) begin
                started <= 1'b1;
            end
            if (eng_rd_en) begin
                popped <= popped + 1'b1;
            end
            if (eng_valid) begin
                issued <= issued + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        mreq_kind <= cfg.cfg.write_mode ? REQ_WRITE : REQ_READ;
        mreq_addr <= cfg.cfg.base + offset;
        mreq_word <= eng_word.data;
    end

    // ---------------------------------------------------------------------------
    // Read data forwarding and completion
    // ---------------------------------------------------------------------------
    assign mem_data.prog_full = ereq_prog_full;
    assign ereq_push          = mem_data.valid && (mem_data.kind == KIND_DATA);
    assign ereq_word          = mem_data.word.data;

    assign all_issued   = (issued == cfg.cfg.count);
    assign all_returned = cfg.cfg.write_mode || (returned == cfg.cfg.count);

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            returned <= '0;
            gen_done <= 1'b0;
        end else begin
            if (ereq_push) begin
                returned <= returned + 1'b1;
            end
            gen_done <= started && cfg_valid && all_issued && all_returned;
        end
    end

endmodule

// ==== logic/memory_response_decoder.sv ====
// Memory response decoder splitting configuration words from data words
`timescale 1ns/1ps

module memory_response_decoder (
    input  logic                   ap_clk,
    input  logic                   areset_read_write_engine,
    input  logic                   fifo_valid,
    input  logic                   fifo_kind,
    input  rw_engine_pkg::mem_word_t fifo_word,
    input  logic                   fifo_empty,
    output logic                   fifo_rd_en,
    output logic                   cfg_valid,
    output rw_engine_pkg::mem_word_t cfg,
    packet_if.source               data
);
    import rw_engine_pkg::*;

    logic is_cfg;
    logic is_data;
    logic seen_data;

    assign is_cfg  = fifo_valid && (fifo_kind == KIND_CONFIG);
    assign is_data = fifo_valid && (fifo_kind == KIND_DATA);

    // Only pop while the generator can take data
    assign fifo_rd_en = !fifo_empty && !data.prog_full;

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            cfg_valid  <= 1'b0;
            data.valid <= 1'b0;
            seen_data  <= 1'b0;
        end else begin
            data.valid <= is_data;
            if (is_cfg) begin
                cfg_valid <= 1'b1;
            end
            if (is_data) begin
                seen_data <= 1'b1;
            end
        end
    end

    // Payload and held configuration
    always_ff @(posedge ap_clk) begin
        data.kind <= fifo_kind;
        data.word <= fifo_word;
        if (is_cfg) begin
            cfg.cfg <= fifo_word.cfg;
        end
    end

    // Configuration must precede the first data word of a run
    a_cfg_before_data: assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
        seen_data |-> !is_cfg);

endmodule

// ==== logic/packet_fifo.sv ====
// Synchronous FIFO with registered read valid, empty, full and prog_full
`timescale 1ns/1ps

module packet_fifo #(
    parameter int WIDTH = 32
) (
    input  logic             ap_clk,
    input  logic             areset_read_write_engine,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);
    import rw_engine_pkg::*;

    logic [WIDTH-1:0]      mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] level;
    logic                  do_wr;
    logic                  do_rd;

    assign empty     = (level == '0);
    assign full      = (level == FIFO_CNT_W'(FIFO_DEPTH));
    assign prog_full = (level >= FIFO_CNT_W'(PROG_THRESH));

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level + FIFO_CNT_W'(do_wr) - FIFO_CNT_W'(do_rd);
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    // Writers gate on prog_full upstream, readers gate on empty
    a_no_over_under_flow: assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
        !(wr_en && full) && !(rd_en && empty));

endmodule

// ==== logic/packet_if.sv ====
// Packet stream interface with source and sink modports
`timescale 1ns/1ps

interface packet_if;
    import rw_engine_pkg::*;

    logic      valid;
    logic      kind;
    mem_word_t word;
    // Sink is close to overflowing, source stops presenting packets
    logic      prog_full;

    modport source (
        output valid,
        output kind,
        output word,
        input  prog_full
    );

    modport sink (
        input  valid,
        input  kind,
        input  word,
        output prog_full
    );

endinterface

// ==== logic/rw_engine_pkg.sv ====
// Widths, FIFO sizing, packet kind codes and the memory word union
package rw_engine_pkg;

    localparam int WORD_W          = 32;
    localparam int ADDR_W          = 16;
    localparam int COUNT_W         = 7;
    localparam int STRIDE_W        = 8;
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_PTR_W      = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W      = $clog2(FIFO_DEPTH + 1);
    localparam int PROG_THRESH     = 12;
    localparam int MAX_OUTSTANDING = 8;
    localparam int CREDIT_W        = $clog2(MAX_OUTSTANDING + 1);

    // Kind bit on the memory response channel
    localparam logic KIND_DATA   = 1'b0;
    localparam logic KIND_CONFIG = 1'b1;

    // Kind bit on memory requests
    localparam logic REQ_READ  = 1'b0;
    localparam logic REQ_WRITE = 1'b1;

    // Response word, seen either as plain data or as a configuration
    typedef union packed {
        logic [WORD_W-1:0] data;
        struct packed {
            logic                write_mode;
            logic [COUNT_W-1:0]  count;
            logic [STRIDE_W-1:0] stride;
            logic [ADDR_W-1:0]   base;
        } cfg;
    } mem_word_t;

    // Stored FIFO entries: {kind, addr, word} and {kind, word}
    localparam int MEM_REQ_W = 1 + ADDR_W + WORD_W;
    localparam int PACKET_W  = 1 + WORD_W;

endpackage
